/* hdl/instr_pkg.sv */
`include "mem_params.svh"

package instr_pkg;

    // Queue index wide enough for either queue.
    localparam int QID_W = ($clog2(`MEM_LDQ_ENTRIES) > $clog2(`MEM_STQ_ENTRIES)) ?
                           $clog2(`MEM_LDQ_ENTRIES) : $clog2(`MEM_STQ_ENTRIES);

    typedef logic [QID_W-1:0] t_qid;
    typedef logic [5:0]       t_robid;
    typedef logic [5:0]       t_pdst;

    typedef enum logic {
        MEM_LOAD,
        MEM_STORE
    } t_mem_kind;

    // Issued memory op, one per cycle.
    typedef struct packed {
        t_mem_kind              kind;
        t_qid                   qid;
        t_robid                 robid;
        t_pdst                  pdst;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`MEM_DATA_W-1:0] data;
    } t_iss_pkt;

endpackage

/* hdl/loadq.sv */
`timescale 1ns/10ps
`include "mem_params.svh"

module loadq (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          flush,
    input  logic                          iss_valid,
    input  instr_pkg::t_iss_pkt           iss_pkt,
    mem_pipe_if.queue                     pipe,
    input  logic                          pipe_valid_mm5,
    input  instr_pkg::t_mem_kind          pipe_kind_mm5,
    input  instr_pkg::t_qid               pipe_qid_mm5,
    input  mem_types_pkg::t_mempipe_action pipe_action_mm5,
    output logic [`MEM_LDQ_ENTRIES-1:0]   e_valid
);

localparam int N = `MEM_LDQ_ENTRIES;

logic [N-1:0]           e_pend;
logic [N-1:0]           e_req;
instr_pkg::t_robid      e_robid [N];
instr_pkg::t_pdst       e_pdst [N];
logic [`MEM_ADDR_W-1:0] e_addr [N];

logic                        sel_found;
instr_pkg::t_qid             sel_idx;
mem_types_pkg::t_mempipe_arb req_pkt;

////////////////////////////////////////////////////////////////////////////
// Entries
////////////////////////////////////////////////////////////////////////////

for (genvar e = 0; e < N; e++) begin : g_ent
    logic alloc;
    logic gnt;
    logic hit_mm5;

    assign alloc   = iss_valid && iss_pkt.kind == instr_pkg::MEM_LOAD &&
                     iss_pkt.qid == instr_pkg::t_qid'(e);
    assign gnt     = pipe.gnt && sel_idx == instr_pkg::t_qid'(e);
    assign hit_mm5 = pipe_valid_mm5 && pipe_kind_mm5 == instr_pkg::MEM_LOAD &&
                     pipe_qid_mm5 == instr_pkg::t_qid'(e);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            e_valid[e] <= 1'b0;
            e_pend[e]  <= 1'b0;
        end else if (flush) begin
            e_valid[e] <= 1'b0;
            e_pend[e]  <= 1'b0;
        end else if (alloc) begin
            e_valid[e] <= 1'b1;
            e_pend[e]  <= 1'b0;
        end else if (hit_mm5 && pipe_action_mm5 == mem_types_pkg::ACT_DONE) begin
            e_valid[e] <= 1'b0;
            e_pend[e]  <= 1'b0;
        end else if (hit_mm5 && pipe_action_mm5 == mem_types_pkg::ACT_REPLAY) begin
            e_pend[e]  <= 1'b0;
        end else if (gnt) begin
            e_pend[e]  <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            e_robid[e] <= iss_pkt.robid;
            e_pdst[e]  <= iss_pkt.pdst;
            e_addr[e]  <= iss_pkt.addr;
        end
    end

    // Ready when valid and not already in the pipe.
    assign e_req[e] = e_valid[e] && !e_pend[e];
end

////////////////////////////////////////////////////////////////////////////
// Find-first pick
////////////////////////////////////////////////////////////////////////////

always_comb begin
    sel_found = 1'b0;
    sel_idx   = '0;
    for (int i = 0; i < N; i++) begin
        if (e_req[i] && !sel_found) begin
            sel_found = 1'b1;
            sel_idx   = instr_pkg::t_qid'(i);
        end
    end
end

always_comb begin
    req_pkt                     = '0;
    req_pkt.kind                = instr_pkg::MEM_LOAD;
    req_pkt.addr                = e_addr[sel_idx];
    req_pkt.payload.tag.robid   = e_robid[sel_idx];
    req_pkt.payload.tag.pdst    = e_pdst[sel_idx];
    req_pkt.payload.tag.qid     = sel_idx;
end

assign pipe.req = sel_found;
assign pipe.pkt = req_pkt;
assign pipe.qid = sel_idx;

// Dispatcher only issues into free entries.
a_alloc_free: assert property (@(posedge clk) disable iff (!rst_n)
    iss_valid && iss_pkt.kind == instr_pkg::MEM_LOAD |-> !e_valid[iss_pkt.qid]);

endmodule

/* hdl/mem_params.svh */
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// Queue depths.
`define MEM_LDQ_ENTRIES 4
`define MEM_STQ_ENTRIES 4

// Word address width, 16 words of data memory.
`define MEM_ADDR_W 4

// Data word width.
`define MEM_DATA_W 32

`endif

/* hdl/mem_pipe.sv */
`timescale 1ns/10ps
`include "mem_params.svh"

module mem_pipe (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           flush,
    mem_pipe_if.arb                        ld_pipe,
    mem_pipe_if.arb                        st_pipe,
    output logic                           pipe_valid_mm5,
    output instr_pkg::t_mem_kind           pipe_kind_mm5,
    output instr_pkg::t_qid                pipe_qid_mm5,
    output mem_types_pkg::t_mempipe_action pipe_action_mm5,
    output logic                           ld_result_valid,
    output instr_pkg::t_robid              ld_result_robid,
    output instr_pkg::t_pdst               ld_result_pdst,
    output logic [`MEM_DATA_W-1:0]         ld_result_data
);

localparam int NSTG  = 5;
localparam int WORDS = 2 ** `MEM_ADDR_W;

logic prio_ld;
logic ld_win;
logic st_win;

logic                        arb_valid;
mem_types_pkg::t_mempipe_arb arb_pkt;
instr_pkg::t_qid             arb_qid;

// Index 0 is mm1, index NSTG-1 is mm5.
logic [NSTG-1:0]             st_valid;
mem_types_pkg::t_mempipe_arb st_pkt [NSTG];
instr_pkg::t_qid             st_qid [NSTG];

logic [`MEM_DATA_W-1:0] mem [WORDS];
logic                   st_hit;
logic                   mm5_load;

////////////////////////////////////////////////////////////////////////////
// Arbiter
////////////////////////////////////////////////////////////////////////////

assign ld_win = ld_pipe.req && (prio_ld || !st_pipe.req);
assign st_win = st_pipe.req && !ld_win;

assign ld_pipe.gnt = ld_win;
assign st_pipe.gnt = st_win;

// Last winner drops to low priority.
always_ff @(posedge clk) begin
    if (!rst_n) begin
        prio_ld <= 1'b1;
    end else if (ld_win) begin
        prio_ld <= 1'b0;
    end else if (st_win) begin
        prio_ld <= 1'b1;
    end
end

assign arb_valid = ld_win || st_win;
assign arb_pkt   = ld_win ? ld_pipe.pkt : st_pipe.pkt;
assign arb_qid   = ld_win ? ld_pipe.qid : st_pipe.qid;

////////////////////////////////////////////////////////////////////////////
// Stages mm1 to mm5
////////////////////////////////////////////////////////////////////////////

always_ff @(posedge clk) begin
    if (!rst_n) begin
        st_valid <= '0;
    end else begin
        st_valid[0] <= arb_valid && !(flush && arb_pkt.kind == instr_pkg::MEM_LOAD);
        for (int s = 1; s < NSTG; s++) begin
            st_valid[s] <= st_valid[s-1] &&
                           !(flush && st_pkt[s-1].kind == instr_pkg::MEM_LOAD);
        end
    end
end

always_ff @(posedge clk) begin
    st_pkt[0] <= arb_pkt;
    st_qid[0] <= arb_qid;
    for (int s = 1; s < NSTG; s++) begin
        st_pkt[s] <= st_pkt[s-1];
        st_qid[s] <= st_qid[s-1];
    end
end

////////////////////////////////////////////////////////////////////////////
// mm5: memory access and replay
////////////////////////////////////////////////////////////////////////////

assign mm5_load = st_valid[NSTG-1] && st_pkt[NSTG-1].kind == instr_pkg::MEM_LOAD;

// Same-address store still on its way to memory.
always_comb begin
    st_hit = 1'b0;
    for (int s = 0; s < NSTG - 1; s++) begin
        if (st_valid[s] && st_pkt[s].kind == instr_pkg::MEM_STORE &&
            st_pkt[s].addr == st_pkt[NSTG-1].addr) begin
            st_hit = 1'b1;
        end
    end
end

always_ff @(posedge clk) begin
    if (!rst_n) begin
        for (int w = 0; w < WORDS; w++) begin
            mem[w] <= '0;
        end
    end else if (st_valid[NSTG-1] && st_pkt[NSTG-1].kind == instr_pkg::MEM_STORE) begin
        mem[st_pkt[NSTG-1].addr] <= st_pkt[NSTG-1].payload.data;
    end
end

assign pipe_valid_mm5  = st_valid[NSTG-1];
assign pipe_kind_mm5   = st_pkt[NSTG-1].kind;
assign pipe_qid_mm5    = st_qid[NSTG-1];
assign pipe_action_mm5 = !st_valid[NSTG-1]     ? mem_types_pkg::ACT_NONE :
                         (mm5_load && st_hit)  ? mem_types_pkg::ACT_REPLAY :
                                                 mem_types_pkg::ACT_DONE;

assign ld_result_valid = mm5_load && !st_hit;
assign ld_result_robid = st_pkt[NSTG-1].payload.tag.robid;
assign ld_result_pdst  = st_pkt[NSTG-1].payload.tag.pdst;
assign ld_result_data  = mem[st_pkt[NSTG-1].addr];

// A request that loses arbitration wins the next cycle.
a_st_served: assert property (@(posedge clk) disable iff (!rst_n)
    st_pipe.req && !st_pipe.gnt |=> st_pipe.gnt);

a_ld_served: assert property (@(posedge clk) disable iff (!rst_n)
    ld_pipe.req && !ld_pipe.gnt && !flush |=> ld_pipe.gnt);

endmodule

/* hdl/mem_pipe_if.sv */
`timescale 1ns/10ps

// One queue's request port into the shared memory pipe.
interface mem_pipe_if;

    logic                        req;
    mem_types_pkg::t_mempipe_arb pkt;
    instr_pkg::t_qid             qid;
    logic                        gnt;

    modport queue (
        output req,
        output pkt,
        output qid,
        input  gnt
    );

    modport arb (
        input  req,
        input  pkt,
        input  qid,
        output gnt
    );

endinterface

/* hdl/mem_types_pkg.sv */
`include "mem_params.svh"

package mem_types_pkg;

    localparam int TAG_W = $bits(instr_pkg::t_robid) + $bits(instr_pkg::t_pdst) +
                           $bits(instr_pkg::t_qid);

    // Load identity carried down the pipe.
    typedef struct packed {
        logic [`MEM_DATA_W-TAG_W-1:0] pad;
        instr_pkg::t_robid            robid;
        instr_pkg::t_pdst             pdst;
        instr_pkg::t_qid              qid;
    } t_ld_tag;

    // Loads carry their tag, stores carry write data.
    typedef union packed {
        t_ld_tag                tag;
        logic [`MEM_DATA_W-1:0] data;
    } t_pipe_payload;

    typedef struct packed {
        instr_pkg::t_mem_kind   kind;
        logic [`MEM_ADDR_W-1:0] addr;
        t_pipe_payload          payload;
    } t_mempipe_arb;

    typedef enum logic [1:0] {
        ACT_NONE,
        ACT_DONE,
        ACT_REPLAY
    } t_mempipe_action;

endpackage

/* hdl/mem_unit.sv */
`timescale 1ns/10ps
`include "mem_params.svh"

module mem_unit (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         iss_valid,
    input  instr_pkg::t_iss_pkt          iss_pkt,
    input  logic                         flush,
    output logic [`MEM_LDQ_ENTRIES-1:0]  ldq_valid,
    output logic [`MEM_STQ_ENTRIES-1:0]  stq_valid,
    output logic                         ld_result_valid,
    output instr_pkg::t_robid            ld_result_robid,
    output instr_pkg::t_pdst             ld_result_pdst,
    output logic [`MEM_DATA_W-1:0]       ld_result_data
);

// mm5 broadcast back to both queues.
logic                           pipe_valid_mm5;
instr_pkg::t_mem_kind           pipe_kind_mm5;
instr_pkg::t_qid                pipe_qid_mm5;
mem_types_pkg::t_mempipe_action pipe_action_mm5;

mem_pipe_if ld_pipe ();
mem_pipe_if st_pipe ();

loadq loadq_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .flush           (flush),
    .iss_valid       (iss_valid),
    .iss_pkt         (iss_pkt),
    .pipe            (ld_pipe),
    .pipe_valid_mm5  (pipe_valid_mm5),
    .pipe_kind_mm5   (pipe_kind_mm5),
    .pipe_qid_mm5    (pipe_qid_mm5),
    .pipe_action_mm5 (pipe_action_mm5),
    .e_valid         (ldq_valid)
);

storeq storeq_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .iss_valid       (iss_valid),
    .iss_pkt         (iss_pkt),
    .pipe            (st_pipe),
    .pipe_valid_mm5  (pipe_valid_mm5),
    .pipe_kind_mm5   (pipe_kind_mm5),
    .pipe_qid_mm5    (pipe_qid_mm5),
    .pipe_action_mm5 (pipe_action_mm5),
    .e_valid         (stq_valid)
);

mem_pipe mem_pipe_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .flush           (flush),
    .ld_pipe         (ld_pipe),
    .st_pipe         (st_pipe),
    .pipe_valid_mm5  (pipe_valid_mm5),
    .pipe_kind_mm5   (pipe_kind_mm5),
    .pipe_qid_mm5    (pipe_qid_mm5),
    .pipe_action_mm5 (pipe_action_mm5),
    .ld_result_valid (ld_result_valid),
    .ld_result_robid (ld_result_robid),
    .ld_result_pdst  (ld_result_pdst),
    .ld_result_data  (ld_result_data)
);

endmodule

/* hdl/storeq.sv */
`timescale 1ns/10ps
`include "mem_params.svh"

module storeq (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          iss_valid,
    input  instr_pkg::t_iss_pkt           iss_pkt,
    mem_pipe_if.queue                     pipe,
    input  logic                          pipe_valid_mm5,
    input  instr_pkg::t_mem_kind          pipe_kind_mm5,
    input  instr_pkg::t_qid               pipe_qid_mm5,
    input  mem_types_pkg::t_mempipe_action pipe_action_mm5,
    output logic [`MEM_STQ_ENTRIES-1:0]   e_valid
);

localparam int N = `MEM_STQ_ENTRIES;

logic [N-1:0]           e_pend;
logic [N-1:0]           e_req;
logic [`MEM_ADDR_W-1:0] e_addr [N];
logic [`MEM_DATA_W-1:0] e_data [N];

logic                        sel_found;
instr_pkg::t_qid             sel_idx;
mem_types_pkg::t_mempipe_arb req_pkt;

////////////////////////////////////////////////////////////////////////////
// Entries
////////////////////////////////////////////////////////////////////////////

for (genvar e = 0; e < N; e++) begin : g_ent
    logic alloc;
    logic gnt;
    logic done_mm5;

    assign alloc    = iss_valid && iss_pkt.kind == instr_pkg::MEM_STORE &&
                      iss_pkt.qid == instr_pkg::t_qid'(e);
    assign gnt      = pipe.gnt && sel_idx == instr_pkg::t_qid'(e);
    assign done_mm5 = pipe_valid_mm5 && pipe_kind_mm5 == instr_pkg::MEM_STORE &&
                      pipe_qid_mm5 == instr_pkg::t_qid'(e) &&
                      pipe_action_mm5 == mem_types_pkg::ACT_DONE;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            e_valid[e] <= 1'b0;
            e_pend[e]  <= 1'b0;
        end else if (alloc) begin
            e_valid[e] <= 1'b1;
            e_pend[e]  <= 1'b0;
        end else if (done_mm5) begin
            e_valid[e] <= 1'b0;
            e_pend[e]  <= 1'b0;
        end else if (gnt) begin
            e_pend[e]  <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            e_addr[e] <= iss_pkt.addr;
            e_data[e] <= iss_pkt.data;
        end
    end

    assign e_req[e] = e_valid[e] && !e_pend[e];
end

////////////////////////////////////////////////////////////////////////////
// Find-first pick
////////////////////////////////////////////////////////////////////////////

always_comb begin
    sel_found = 1'b0;
    sel_idx   = '0;
    for (int i = 0; i < N; i++) begin
        if (e_req[i] && !sel_found) begin
            sel_found = 1'b1;
            sel_idx   = instr_pkg::t_qid'(i);
        end
    end
end

// Store data rides in the payload.
always_comb begin
    req_pkt              = '0;
    req_pkt.kind         = instr_pkg::MEM_STORE;
    req_pkt.addr         = e_addr[sel_idx];
    req_pkt.payload.data = e_data[sel_idx];
end

assign pipe.req = sel_found;
assign pipe.pkt = req_pkt;
assign pipe.qid = sel_idx;

a_alloc_free: assert property (@(posedge clk) disable iff (!rst_n)
    iss_valid && iss_pkt.kind == instr_pkg::MEM_STORE |-> !e_valid[iss_pkt.qid]);

a_no_store_replay: assert property (@(posedge clk) disable iff (!rst_n)
    pipe_valid_mm5 && pipe_kind_mm5 == instr_pkg::MEM_STORE
    |-> pipe_action_mm5 != mem_types_pkg::ACT_REPLAY);

endmodule

/* mem_unit.f */
+incdir+hdl
hdl/instr_pkg.sv
hdl/mem_types_pkg.sv
hdl/mem_pipe_if.sv
hdl/loadq.sv
hdl/storeq.sv
hdl/mem_pipe.sv
hdl/mem_unit.sv
verification/mem_unit_checker.sv
verification/mem_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the mem_unit testbench with Verilator, then check the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f mem_unit.f --top-module mem_unit_tb \
    -o mem_unit_sim > build.log 2>&1 \
    && ./obj_dir/mem_unit_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -qx "test passed" sim.log && exit 0 || exit 1

/* verification/mem_unit_checker.sv */
`timescale 1ns/10ps
`include "mem_params.svh"

module mem_unit_checker (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        iss_valid,
    input  instr_pkg::t_iss_pkt         iss_pkt,
    input  logic                        flush,
    input  logic [`MEM_LDQ_ENTRIES-1:0] ldq_valid,
    input  logic [`MEM_STQ_ENTRIES-1:0] stq_valid,
    input  logic                        ld_result_valid,
    input  instr_pkg::t_robid           ld_result_robid,
    input  instr_pkg::t_pdst            ld_result_pdst,
    input  logic [`MEM_DATA_W-1:0]      ld_result_data,
    input  logic                        bound_en,
    input  logic                        drain_check,
    output int                          error_count
);

localparam int NLD        = `MEM_LDQ_ENTRIES;
localparam int NST        = `MEM_STQ_ENTRIES;
localparam int WORDS      = 2 ** `MEM_ADDR_W;
localparam int WAIT_BOUND = 12;

logic [`MEM_DATA_W-1:0] model_mem [WORDS];

// Outstanding loads by ldq index.
logic [NLD-1:0]         ld_out;
logic [NLD-1:0]         ld_clear_due;
logic                   flush_due;
instr_pkg::t_robid      ld_robid [NLD];
instr_pkg::t_pdst       ld_pdst [NLD];
logic [`MEM_ADDR_W-1:0] ld_addr [NLD];

// Saved store issues by stq index.
logic [NST-1:0]         stq_prev;
logic [`MEM_ADDR_W-1:0] st_addr [NST];
logic [`MEM_DATA_W-1:0] st_data [NST];

int ld_wait;
int st_wait;

////////////////////////////////////////////////////////////////////////////
// Sampled mid-cycle, when every port is settled
////////////////////////////////////////////////////////////////////////////

always @(negedge clk) begin
    int                     hit;
    logic                   ld_done;
    logic                   st_done;
    logic [`MEM_DATA_W-1:0] exp_data;
    hit     = -1;
    ld_done = 1'b0;
    st_done = 1'b0;
    if (!rst_n) begin
        for (int w = 0; w < WORDS; w++) begin
            model_mem[w] = '0;
        end
        ld_out       = '0;
        ld_clear_due = '0;
        flush_due    = 1'b0;
        stq_prev     = '0;
        ld_wait      = 0;
        st_wait      = 0;
        error_count  = 0;
    end else begin
        for (int q = 0; q < NLD; q++) begin
            if (ld_clear_due[q] && ldq_valid[q]) begin
                $display("Mismatch ldq_valid: got %h, expected bit %0d clear after its result",
                         ldq_valid, q);
                error_count++;
            end
        end
        ld_clear_due = '0;
        if (flush_due && ldq_valid != '0) begin
            $display("Mismatch ldq_valid after flush: got %h, expected 0", ldq_valid);
            error_count++;
        end
        flush_due = 1'b0;

        // Store commits on the edge its entry frees.
        for (int i = 0; i < NST; i++) begin
            if (stq_prev[i] && !stq_valid[i]) begin
                model_mem[st_addr[i]] = st_data[i];
                st_done = 1'b1;
            end
        end

        if (ld_result_valid) begin
            for (int q = 0; q < NLD; q++) begin
                if (ld_out[q] && ld_robid[q] == ld_result_robid) begin
                    hit = q;
                end
            end
            if (hit < 0) begin
                $display("Mismatch ld_result_robid: got %h, no outstanding load has it at %0t",
                         ld_result_robid, $time);
                error_count++;
            end else begin
                exp_data = model_mem[ld_addr[hit]];
                if (ld_result_pdst != ld_pdst[hit]) begin
                    $display("Mismatch ld_result_pdst: got %h, expected %h at %0t",
                             ld_result_pdst, ld_pdst[hit], $time);
                    error_count++;
                end
                if (ld_result_data != exp_data) begin
                    $display("Mismatch ld_result_data: got %h, expected %h at %0t",
                             ld_result_data, exp_data, $time);
                    error_count++;
                end
                ld_out[hit]       = 1'b0;
                ld_clear_due[hit] = 1'b1;
                ld_done           = 1'b1;
            end
        end

        // Flushed loads may not return later.
        if (flush) begin
            ld_out    = '0;
            flush_due = 1'b1;
        end

        if (iss_valid && iss_pkt.kind == instr_pkg::MEM_LOAD) begin
            ld_out[iss_pkt.qid]   = 1'b1;
            ld_robid[iss_pkt.qid] = iss_pkt.robid;
            ld_pdst[iss_pkt.qid]  = iss_pkt.pdst;
            ld_addr[iss_pkt.qid]  = iss_pkt.addr;
        end else if (iss_valid) begin
            st_addr[iss_pkt.qid] = iss_pkt.addr;
            st_data[iss_pkt.qid] = iss_pkt.data;
        end
        stq_prev = stq_valid;

        // Wait counters only run while a queue holds work.
        if (bound_en && ldq_valid != '0 && !ld_done) begin
            ld_wait++;
        end else begin
            ld_wait = 0;
        end
        if (bound_en && stq_valid != '0 && !st_done) begin
            st_wait++;
        end else begin
            st_wait = 0;
        end
        if (ld_wait > WAIT_BOUND) begin
            $display("Load queue waited over %0d cycles for a completion", WAIT_BOUND);
            error_count++;
            ld_wait = 0;
        end
        if (st_wait > WAIT_BOUND) begin
            $display("Store queue waited over %0d cycles for a completion", WAIT_BOUND);
            error_count++;
            st_wait = 0;
        end

        if (drain_check) begin
            if (ldq_valid != '0) begin
                $display("Mismatch ldq_valid after drain: got %h, expected 0", ldq_valid);
                error_count++;
            end
            if (stq_valid != '0) begin
                $display("Mismatch stq_valid after drain: got %h, expected 0", stq_valid);
                error_count++;
            end
            if (ld_out != '0) begin
                $display("Loads issued but never returned, entry mask %h", ld_out);
                error_count++;
            end
        end
    end
end

endmodule

/* verification/mem_unit_tb.sv */
`timescale 1ns/10ps
`include "mem_params.svh"

module mem_unit_tb;

localparam int CLK_NS       = 8;
localparam int RESET_CYCLES = 4;
localparam int PHASE_CYCLES = 300;
localparam int DRAIN_CYCLES = 100;
localparam int NUM_PHASES   = 4;
localparam int TIMEOUT_NS   = (NUM_PHASES * (PHASE_CYCLES + DRAIN_CYCLES) + RESET_CYCLES)
                              * CLK_NS * 3 / 2;

logic                        clk;
logic                        rst_n;
logic                        iss_valid;
instr_pkg::t_iss_pkt         iss_pkt;
logic                        flush;
logic [`MEM_LDQ_ENTRIES-1:0] ldq_valid;
logic [`MEM_STQ_ENTRIES-1:0] stq_valid;
logic                        ld_result_valid;
instr_pkg::t_robid           ld_result_robid;
instr_pkg::t_pdst            ld_result_pdst;
logic [`MEM_DATA_W-1:0]      ld_result_data;

logic              bound_en;
logic              drain_check;
int                error_count;
integer            seed;
instr_pkg::t_robid robid_next;

always #(CLK_NS / 2) clk = ~clk;

mem_unit mem_unit_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .iss_valid       (iss_valid),
    .iss_pkt         (iss_pkt),
    .flush           (flush),
    .ldq_valid       (ldq_valid),
    .stq_valid       (stq_valid),
    .ld_result_valid (ld_result_valid),
    .ld_result_robid (ld_result_robid),
    .ld_result_pdst  (ld_result_pdst),
    .ld_result_data  (ld_result_data)
);

mem_unit_checker mem_unit_checker_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .iss_valid       (iss_valid),
    .iss_pkt         (iss_pkt),
    .flush           (flush),
    .ldq_valid       (ldq_valid),
    .stq_valid       (stq_valid),
    .ld_result_valid (ld_result_valid),
    .ld_result_robid (ld_result_robid),
    .ld_result_pdst  (ld_result_pdst),
    .ld_result_data  (ld_result_data),
    .bound_en        (bound_en),
    .drain_check     (drain_check),
    .error_count     (error_count)
);

////////////////////////////////////////////////////////////////////////////
// Stimulus
////////////////////////////////////////////////////////////////////////////

// First free entry, scanning from a random start.
function automatic int free_slot(input logic [31:0] busy, input int n, input int start);
    int idx;
    free_slot = -1;
    for (int k = 0; k < n; k++) begin
        idx = (start + k) % n;
        if (!busy[idx] && free_slot < 0) begin
            free_slot = idx;
        end
    end
endfunction

function automatic string phase_name(input int p);
    case (p)
        1:       return "loads from reset memory";
        2:       return "mixed traffic";
        3:       return "flush";
        default: return "contention";
    endcase
endfunction

// Mode 1 loads only, 2 mixed, 3 mixed with flushes, 4 both queues kept full.
task automatic drive_stim(input int mode);
    logic [31:0] rnd;
    logic [31:0] wdata;
    logic        want_ld;
    int          slot;
    rnd       = $random(seed);
    wdata     = $random(seed);
    iss_valid = 1'b0;
    flush     = 1'b0;
    iss_pkt   = '0;
    if (mode == 3 && rnd[4:0] == 5'd0) begin
        flush = 1'b1;
    end else if (mode == 4 || rnd[6:5] != 2'd0) begin
        if (mode == 1) begin
            want_ld = 1'b1;
        end else if (mode == 4 && $countones(ldq_valid) != $countones(stq_valid)) begin
            want_ld = $countones(ldq_valid) < $countones(stq_valid);
        end else begin
            want_ld = rnd[7];
        end
        if (want_ld) begin
            slot = free_slot(32'(ldq_valid), `MEM_LDQ_ENTRIES, int'(rnd[10:8]));
        end else begin
            slot = free_slot(32'(stq_valid), `MEM_STQ_ENTRIES, int'(rnd[10:8]));
        end
        if (slot < 0 && mode != 1) begin
            want_ld = !want_ld;
            if (want_ld) begin
                slot = free_slot(32'(ldq_valid), `MEM_LDQ_ENTRIES, int'(rnd[10:8]));
            end else begin
                slot = free_slot(32'(stq_valid), `MEM_STQ_ENTRIES, int'(rnd[10:8]));
            end
        end
        if (slot >= 0) begin
            iss_valid     = 1'b1;
            iss_pkt.kind  = want_ld ? instr_pkg::MEM_LOAD : instr_pkg::MEM_STORE;
            iss_pkt.qid   = instr_pkg::t_qid'(slot);
            iss_pkt.robid = robid_next;
            iss_pkt.pdst  = rnd[16:11];
            iss_pkt.addr  = rnd[20+`MEM_ADDR_W-1:20];
            // Four hot words, so loads meet stores in flight.
            if (mode != 4) begin
                iss_pkt.addr[`MEM_ADDR_W-1:2] = '0;
            end
            iss_pkt.data  = want_ld ? '0 : wdata;
            robid_next    = robid_next + 6'd1;
        end
    end
endtask

task automatic run_phase(input int mode);
    bound_en = (mode == 4);
    repeat (PHASE_CYCLES) begin
        @(posedge clk);
        #1;
        drive_stim(mode);
    end
    @(posedge clk);
    #1;
    iss_valid = 1'b0;
    flush     = 1'b0;
    bound_en  = 1'b0;
    repeat (DRAIN_CYCLES - 1) @(posedge clk);
    #1;
    drain_check = 1'b1;
    @(posedge clk);
    #1;
    drain_check = 1'b0;
endtask

////////////////////////////////////////////////////////////////////////////
// Main sequence and watchdog
////////////////////////////////////////////////////////////////////////////

initial begin
    int fails;
    int errs_before;
    clk         = 1'b0;
    rst_n       = 1'b0;
    iss_valid   = 1'b0;
    iss_pkt     = '0;
    flush       = 1'b0;
    bound_en    = 1'b0;
    drain_check = 1'b0;
    seed        = 62;
    robid_next  = '0;
    fails       = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int p = 1; p <= NUM_PHASES; p++) begin
        errs_before = error_count;
        run_phase(p);
        if (error_count == errs_before) begin
            $display("Phase %0d, %s: ok", p, phase_name(p));
        end else begin
            $display("Phase %0d, %s: FAILED with %0d errors", p, phase_name(p),
                     error_count - errs_before);
            fails++;
        end
    end
    $display("Phases run %0d, ok %0d, failed %0d, errors %0d",
             NUM_PHASES, NUM_PHASES - fails, fails, error_count);
    if (fails == 0 && error_count == 0) begin
        $display("test passed");
    end else begin
        $display("test failed");
    end
    $finish;
end

initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("test failed");
    $finish;
end

endmodule
